// File: src.f
+incdir+tests
source/commit_pkg.sv
source/mem_stage.sv
source/wb_stage.sv
source/csr_file.sv
source/reg_file.sv
source/commit_top.sv
tests/commit_tb.sv

// File: Bender.yml
package:
  name: commit

sources:
  - files:
      - source/commit_pkg.sv
      - source/mem_stage.sv
      - source/wb_stage.sv
      - source/csr_file.sv
      - source/reg_file.sv
      - source/commit_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/commit_tb.sv

// File: tests/commit_ref.svh
`ifndef COMMIT_REF_SVH
`define COMMIT_REF_SVH

// one predicted commit event two edges after acceptance
typedef struct packed {
    trace_t tr;
    logic   fl;
    word_t  target;
    word_t  cycle;
} expect_t;

word_t ref_regs [32];
word_t ref_crmd;
word_t ref_prmd;
word_t ref_estat;
word_t ref_era;
word_t ref_eentry;
word_t ref_save0;

function automatic void reset_ref();
    for (int r = 0; r < 32; r++) begin
        ref_regs[r] = '0;
    end
    ref_crmd   = '0;
    ref_prmd   = '0;
    ref_estat  = '0;
    ref_era    = '0;
    ref_eentry = '0;
    ref_save0  = '0;
endfunction

function automatic word_t ref_csr_read(input csr_num_t num);
    case (num)
        CSR_CRMD:   return ref_crmd;
        CSR_PRMD:   return ref_prmd;
        CSR_ESTAT:  return ref_estat;
        CSR_ERA:    return ref_era;
        CSR_EENTRY: return ref_eentry;
        CSR_SAVE0:  return ref_save0;
        default:    return 32'h0;
    endcase
endfunction

// architected writable fields of each csr
function automatic void ref_csr_write(input csr_num_t num, input word_t value,
                                      input word_t mask);
    word_t bits;
    word_t merged;
    case (num)
        CSR_CRMD:   bits = mask & 32'h0000_01ff;
        CSR_PRMD:   bits = mask & 32'h0000_0007;
        CSR_ESTAT:  bits = mask & 32'h0000_0003;
        CSR_EENTRY: bits = mask & 32'hffff_ffc0;
        default:    bits = mask;
    endcase
    merged = (ref_csr_read(num) & ~bits) | (value & bits);
    case (num)
        CSR_CRMD:   ref_crmd = merged;
        CSR_PRMD:   ref_prmd = merged;
        CSR_ESTAT:  ref_estat = merged;
        CSR_ERA:    ref_era = merged;
        CSR_EENTRY: ref_eentry = merged;
        CSR_SAVE0:  ref_save0 = merged;
        default: begin
        end
    endcase
endfunction

function automatic word_t ref_load_value(input load_op_e op, input word_t addr,
                                         input word_t rdata);
    word_t shifted;
    shifted = rdata >> (addr[1:0] * 8);
    case (op)
        LOAD_B:  return {{24{shifted[7]}}, shifted[7:0]};
        LOAD_BU: return {24'h0, shifted[7:0]};
        LOAD_H:  return {{16{shifted[15]}}, shifted[15:0]};
        LOAD_HU: return {16'h0, shifted[15:0]};
        LOAD_W:  return rdata;
        default: return addr;
    endcase
endfunction

// expected commit of one accepted instruction, then the state it leaves
function automatic expect_t predict_commit(input ex_to_mem_t ins, input word_t rdata);
    expect_t e;
    logic    mis;
    logic    ex;
    word_t   data;
    mis = ((ins.load_op == LOAD_H || ins.load_op == LOAD_HU) && ins.alu_result[0])
        || (ins.load_op == LOAD_W && ins.alu_result[1:0] != 2'b00);
    ex = ins.ex_en || mis;
    data = ins.csr_re ? ref_csr_read(ins.csr_num)
                      : ref_load_value(ins.load_op, ins.alu_result, rdata);
    e.tr.pc       = ins.pc;
    e.tr.rf_we    = ins.rf_we && !ex && !ins.ertn;
    e.tr.rf_wnum  = ins.rf_waddr;
    e.tr.rf_wdata = data;
    e.fl          = ex || ins.ertn;
    e.target      = ex ? ref_eentry : ref_era;
    e.cycle       = '0;
    if (e.tr.rf_we && ins.rf_waddr != 5'd0) begin
        ref_regs[ins.rf_waddr] = data;
    end
    if (ex) begin
        ref_prmd[2:0]   = ref_crmd[2:0];
        ref_crmd[2:0]   = 3'b000;
        ref_era         = ins.pc;
        ref_estat[21:16] = ins.ex_en ? ins.ecode : ECODE_ALE;
        ref_estat[30:22] = ins.ex_en ? ins.esubcode : 9'd0;
    end else if (ins.ertn) begin
        ref_crmd[2:0] = ref_prmd[2:0];
    end else if (ins.csr_we) begin
        ref_csr_write(ins.csr_num, ins.csr_wvalue, ins.csr_wmask);
    end
    return e;
endfunction

`endif

// File: tests/commit_tb.sv
module commit_tb import commit_pkg::*; ();

    logic       clk;
    logic       resetn;
    logic       in_valid;
    ex_to_mem_t in_bus;
    word_t      mem_rdata;
    reg_addr_t  rf_raddr1;
    reg_addr_t  rf_raddr2;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    trace_t     trace;
    logic       flush;
    word_t      flush_target;

    `include "commit_ref.svh"

    integer  seed;
    word_t   cycle;
    word_t   next_rdata;
    string   test_name;
    expect_t expect_q [$];

    commit_top u_dut (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_bus       (in_bus),
        .mem_rdata    (mem_rdata),
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .trace        (trace),
        .flush        (flush),
        .flush_target (flush_target)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    initial cycle = '0;
    always @(posedge clk) cycle <= cycle + 1;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_trace(input string what, input trace_t expected, input trace_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error [%s] %s: expected %h, actual %h",
                                test_name, what, expected, actual));
        end
    endtask

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error [%s] %s: expected %h, actual %h",
                                test_name, what, expected, actual));
        end
    endtask

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic word_t rand_pc();
        return rand_word() & 32'hffff_fffc;
    endfunction

    function automatic reg_addr_t rand_rd();
        return reg_addr_t'(1 + rand_word() % 31);
    endfunction

    function automatic ex_to_mem_t alu_instr(input reg_addr_t rd, input word_t value);
        ex_to_mem_t ins;
        ins            = '0;
        ins.pc         = rand_pc();
        ins.rf_we      = 1'b1;
        ins.rf_waddr   = rd;
        ins.alu_result = value;
        ins.load_op    = LOAD_NONE;
        return ins;
    endfunction

    function automatic ex_to_mem_t load_instr(input load_op_e op, input word_t addr);
        ex_to_mem_t ins;
        ins         = alu_instr(rand_rd(), addr);
        ins.load_op = op;
        return ins;
    endfunction

    function automatic ex_to_mem_t csr_instr(input csr_num_t num, input logic re, input logic we,
                                             input word_t mask, input word_t value);
        ex_to_mem_t ins;
        ins            = alu_instr(rand_rd(), 32'h0);
        ins.csr_re     = re;
        ins.csr_we     = we;
        ins.csr_num    = num;
        ins.csr_wmask  = mask;
        ins.csr_wvalue = value;
        return ins;
    endfunction

    // load data follows its instruction by one slot
    task automatic drive_slot(input logic valid, input ex_to_mem_t ins, input word_t rdata);
        @(negedge clk);
        mem_rdata  = next_rdata;
        in_valid   = valid;
        in_bus     = ins;
        next_rdata = rdata;
    endtask

    // a flushing instruction is followed by two slots the core must drop
    task automatic issue(input ex_to_mem_t ins, input word_t rdata);
        expect_t e;
        drive_slot(1'b1, ins, rdata);
        e = predict_commit(ins, rdata);
        e.cycle = cycle + 2;
        if (e.tr.rf_we || e.fl) begin
            expect_q.push_back(e);
        end
        if (e.fl) begin
            drive_slot(1'b1, alu_instr(rand_rd(), rand_word()), rand_word());
            drive_slot(1'b1, alu_instr(rand_rd(), rand_word()), rand_word());
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expect_q.size() != 0) begin
            if (waited == 20) begin
                abort_run($sformatf("timeout in %s: a predicted trace or flush never came",
                                    test_name));
            end
            drive_slot(1'b0, '0, '0);
            waited++;
        end
        // let the last write land
        drive_slot(1'b0, '0, '0);
        drive_slot(1'b0, '0, '0);
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            rf_raddr1 = reg_addr_t'(r);
            rf_raddr2 = reg_addr_t'(31 - r);
            #10;
            check_word($sformatf("rf_rdata1 r%0d", r), ref_regs[r], rf_rdata1);
            check_word($sformatf("rf_rdata2 r%0d", 31 - r), ref_regs[31 - r], rf_rdata2);
        end
    endtask

    always @(negedge clk) begin : commit_monitor
        expect_t e;
        if (trace.rf_we !== 1'b0 || flush !== 1'b0) begin
            if (expect_q.size() == 0) begin
                abort_run($sformatf("unexpected commit at pc %h while nothing was pending",
                                    trace.pc));
            end else begin
                e = expect_q.pop_front();
                check_word("event cycle", e.cycle, cycle);
                check_word("flush", word_t'(e.fl), word_t'(flush));
                if (e.fl) begin
                    check_word("flush target", e.target, flush_target);
                    check_word("trace pc", e.tr.pc, trace.pc);
                    check_word("trace rf_we", word_t'(e.tr.rf_we), word_t'(trace.rf_we));
                end else begin
                    check_trace("trace", e.tr, trace);
                end
            end
        end
    end

    initial begin
        load_op_e   op;
        word_t      addr;
        ex_to_mem_t ins;
        csr_num_t   csr_list [7];
        seed       = 67;
        resetn     = 1'b0;
        in_valid   = 1'b0;
        in_bus     = '0;
        mem_rdata  = '0;
        rf_raddr1  = '0;
        rf_raddr2  = '0;
        next_rdata = '0;
        csr_list   = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA, CSR_EENTRY, CSR_SAVE0, 14'h2};
        reset_ref();

        test_name = "reset";
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        issue(csr_instr(CSR_CRMD, 1'b1, 1'b0, '0, '0), '0);
        drain();

        test_name = "alu writes";
        for (int r = 1; r < 32; r++) begin
            issue(alu_instr(reg_addr_t'(r), rand_word()), rand_word());
        end
        for (int i = 0; i < 40; i++) begin
            if (rand_word() % 4 == 0) begin
                drive_slot(1'b0, '0, rand_word());
            end
            issue(alu_instr(reg_addr_t'(rand_word()), rand_word()), rand_word());
        end
        drain();
        check_regs();

        test_name = "loads";
        for (int i = 0; i < 40; i++) begin
            op   = load_op_e'(1 + rand_word() % 5);
            addr = rand_word();
            if (op == LOAD_H || op == LOAD_HU) begin
                addr[0] = 1'b0;
            end else if (op == LOAD_W) begin
                addr[1:0] = 2'b00;
            end
            issue(load_instr(op, addr), rand_word());
        end
        drain();
        check_regs();

        // csrwr, csrrd, csrxchg, csrrd on every number
        test_name = "csr access";
        for (int k = 0; k < 7; k++) begin
            issue(csr_instr(csr_list[k], 1'b1, 1'b1, '1, rand_word()), '0);
            issue(csr_instr(csr_list[k], 1'b1, 1'b0, '0, '0), '0);
            issue(csr_instr(csr_list[k], 1'b1, 1'b1, rand_word(), rand_word()), '0);
            issue(csr_instr(csr_list[k], 1'b1, 1'b0, '0, '0), '0);
        end
        drain();

        test_name = "exceptions";
        for (int i = 0; i < 3; i++) begin
            issue(csr_instr(CSR_EENTRY, 1'b0, 1'b1, '1, rand_word()), '0);
            issue(csr_instr(CSR_CRMD, 1'b0, 1'b1, 32'h7, rand_word()), '0);
            ins          = alu_instr(rand_rd(), rand_word());
            ins.ex_en    = 1'b1;
            ins.ecode    = ecode_t'(rand_word());
            ins.esubcode = esubcode_t'(rand_word());
            issue(ins, '0);
            issue(csr_instr(CSR_ERA, 1'b1, 1'b0, '0, '0), '0);
            issue(csr_instr(CSR_ESTAT, 1'b1, 1'b0, '0, '0), '0);
            issue(csr_instr(CSR_PRMD, 1'b1, 1'b0, '0, '0), '0);
            // misaligned half and word loads
            issue(csr_instr(CSR_CRMD, 1'b0, 1'b1, 32'h7, rand_word()), '0);
            issue(load_instr(LOAD_H, rand_word() | 32'h1), rand_word());
            issue(csr_instr(CSR_ESTAT, 1'b1, 1'b0, '0, '0), '0);
            issue(load_instr(LOAD_W, rand_pc() | 32'h2), rand_word());
            issue(csr_instr(CSR_ERA, 1'b1, 1'b0, '0, '0), '0);
            issue(csr_instr(CSR_ESTAT, 1'b1, 1'b0, '0, '0), '0);
            issue(csr_instr(CSR_PRMD, 1'b1, 1'b0, '0, '0), '0);
        end
        drain();
        check_regs();

        test_name = "ertn";
        for (int i = 0; i < 4; i++) begin
            issue(csr_instr(CSR_PRMD, 1'b0, 1'b1, '1, rand_word()), '0);
            issue(csr_instr(CSR_ERA, 1'b0, 1'b1, '1, rand_word()), '0);
            ins      = '0;
            ins.pc   = rand_pc();
            ins.ertn = 1'b1;
            issue(ins, '0);
            issue(csr_instr(CSR_CRMD, 1'b1, 1'b0, '0, '0), '0);
        end
        drain();
        check_regs();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: source/commit_top.sv
module commit_top import commit_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       in_valid,
    input  ex_to_mem_t in_bus,
    input  word_t      mem_rdata,
    input  reg_addr_t  rf_raddr1,
    input  reg_addr_t  rf_raddr2,
    output word_t      rf_rdata1,
    output word_t      rf_rdata2,
    output trace_t     trace,
    output logic       flush,
    output word_t      flush_target
);

    logic       mem_valid;
    mem_to_wb_t mem_bus;

    csr_req_t  csr_req;
    exc_req_t  exc_req;
    word_t     csr_rvalue;
    word_t     era;
    word_t     eentry;

    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    mem_stage u_mem_stage (
        .clk       (clk),
        .resetn    (resetn),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_bus    (in_bus),
        .mem_rdata (mem_rdata),
        .mem_valid (mem_valid),
        .mem_bus   (mem_bus)
    );

    wb_stage u_wb_stage (
        .clk          (clk),
        .resetn       (resetn),
        .mem_valid    (mem_valid),
        .mem_bus      (mem_bus),
        .csr_rvalue   (csr_rvalue),
        .era          (era),
        .eentry       (eentry),
        .csr_req      (csr_req),
        .exc_req      (exc_req),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .trace        (trace),
        .flush        (flush),
        .flush_target (flush_target)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .resetn     (resetn),
        .csr_req    (csr_req),
        .exc_req    (exc_req),
        .csr_rvalue (csr_rvalue),
        .era        (era),
        .eentry     (eentry)
    );

endmodule

// File: source/reg_file.sv
module reg_file import commit_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: source/csr_file.sv
module csr_file import commit_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  csr_req_t csr_req,
    input  exc_req_t exc_req,
    output word_t    csr_rvalue,
    output word_t    era,
    output word_t    eentry
);

    word_t crmd_q;
    word_t prmd_q;
    word_t estat_q;
    word_t era_q;
    word_t eentry_q;
    word_t save0_q;

    word_t rd_value;

    // replace only the bits allowed by both the request and the field
    function automatic word_t masked_write(input word_t old_value, input word_t wvalue,
                                           input word_t wmask, input word_t field);
        word_t m;
        m = wmask & field;
        return (old_value & ~m) | (wvalue & m);
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_q   <= '0;
            prmd_q   <= '0;
            estat_q  <= '0;
            era_q    <= '0;
            eentry_q <= '0;
            save0_q  <= '0;
        end else if (exc_req.ex) begin
            // exception entry saves the mode and drops to plv 0
            prmd_q[1:0]    <= crmd_q[1:0];
            prmd_q[2]      <= crmd_q[2];
            crmd_q[1:0]    <= 2'b00;
            crmd_q[2]      <= 1'b0;
            era_q          <= exc_req.pc;
            estat_q[21:16] <= exc_req.ecode;
            estat_q[30:22] <= exc_req.esubcode;
        end else if (exc_req.ertn) begin
            crmd_q[1:0] <= prmd_q[1:0];
            crmd_q[2]   <= prmd_q[2];
        end else if (csr_req.we) begin
            case (csr_req.num)
                CSR_CRMD: begin
                    crmd_q <= masked_write(crmd_q, csr_req.wvalue, csr_req.wmask, CRMD_WMASK);
                end
                CSR_PRMD: begin
                    prmd_q <= masked_write(prmd_q, csr_req.wvalue, csr_req.wmask, PRMD_WMASK);
                end
                CSR_ESTAT: begin
                    estat_q <= masked_write(estat_q, csr_req.wvalue, csr_req.wmask,
                                            ESTAT_WMASK);
                end
                CSR_ERA: begin
                    era_q <= masked_write(era_q, csr_req.wvalue, csr_req.wmask, '1);
                end
                CSR_EENTRY: begin
                    eentry_q <= masked_write(eentry_q, csr_req.wvalue, csr_req.wmask,
                                             EENTRY_WMASK);
                end
                CSR_SAVE0: begin
                    save0_q <= masked_write(save0_q, csr_req.wvalue, csr_req.wmask, '1);
                end
                default: begin
                end
            endcase
        end
    end

    // unimplemented numbers read zero
    always_comb begin
        case (csr_req.num)
            CSR_CRMD:   rd_value = crmd_q;
            CSR_PRMD:   rd_value = prmd_q;
            CSR_ESTAT:  rd_value = estat_q;
            CSR_ERA:    rd_value = era_q;
            CSR_EENTRY: rd_value = eentry_q;
            CSR_SAVE0:  rd_value = save0_q;
            default:    rd_value = '0;
        endcase
    end

    assign csr_rvalue = csr_req.re ? rd_value : '0;
    assign era        = era_q;
    assign eentry     = eentry_q;

    // a write would be silently lost behind exception entry
    a_no_write_on_ex: assert property (@(posedge clk) disable iff (!resetn)
        !(csr_req.we && exc_req.ex));

endmodule

// File: source/wb_stage.sv
module wb_stage import commit_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       mem_valid,
    input  mem_to_wb_t mem_bus,
    input  word_t      csr_rvalue,
    input  word_t      era,
    input  word_t      eentry,
    output csr_req_t   csr_req,
    output exc_req_t   exc_req,
    output logic       rf_we,
    output reg_addr_t  rf_waddr,
    output word_t      rf_wdata,
    output trace_t     trace,
    output logic       flush,
    output word_t      flush_target
);

    logic       wb_valid;
    mem_to_wb_t wb_q;

    logic  wb_ex;
    logic  wb_ertn;
    logic  commit_we;
    word_t final_wdata;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (flush) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_q <= mem_bus;
    end

    // every side effect needs an instruction in writeback
    assign wb_ex   = wb_valid && wb_q.ex_en;
    assign wb_ertn = wb_valid && wb_q.ertn;

    assign commit_we   = wb_valid && wb_q.rf_we && !wb_q.ex_en && !wb_q.ertn;
    assign final_wdata = wb_q.csr_re ? csr_rvalue : wb_q.rf_wdata;

    assign rf_we    = commit_we;
    assign rf_waddr = wb_q.rf_waddr;
    assign rf_wdata = final_wdata;

    assign trace.pc       = wb_q.pc;
    assign trace.rf_we    = commit_we;
    assign trace.rf_wnum  = wb_q.rf_waddr;
    assign trace.rf_wdata = final_wdata;

    assign csr_req.re     = wb_valid && wb_q.csr_re;
    assign csr_req.we     = wb_valid && wb_q.csr_we;
    assign csr_req.num    = wb_q.csr_num;
    assign csr_req.wmask  = wb_q.csr_wmask;
    assign csr_req.wvalue = wb_q.csr_wvalue;

    assign exc_req.ex       = wb_ex;
    assign exc_req.ecode    = wb_q.ecode;
    assign exc_req.esubcode = wb_q.esubcode;
    assign exc_req.pc       = wb_q.pc;
    assign exc_req.ertn     = wb_ertn;

    // redirect fetch to the handler or back to the saved pc
    assign flush        = wb_ex || wb_ertn;
    assign flush_target = wb_ex ? eentry : era;

    // an ALE raised in the memory stage must never land on an ertn
    a_ex_ertn_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(exc_req.ex && exc_req.ertn));

endmodule

// File: source/mem_stage.sv
module mem_stage import commit_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  logic       flush,
    input  logic       in_valid,
    input  ex_to_mem_t in_bus,
    input  word_t      mem_rdata,
    output logic       mem_valid,
    output mem_to_wb_t mem_bus
);

    logic       valid_q;
    ex_to_mem_t ex_q;

    logic [1:0] addr_lo;
    logic [7:0] load_byte;
    logic [15:0] load_half;
    word_t      load_data;
    logic       misaligned;
    logic       ale;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // payload only moves on an accepted instruction
    always_ff @(posedge clk) begin
        if (in_valid && !flush) begin
            ex_q <= in_bus;
        end
    end

    assign addr_lo   = ex_q.alu_result[1:0];
    assign load_byte = mem_rdata[8*addr_lo +: 8];
    assign load_half = addr_lo[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (ex_q.load_op)
            LOAD_B:  load_data = {{24{load_byte[7]}}, load_byte};
            LOAD_BU: load_data = {24'b0, load_byte};
            LOAD_H:  load_data = {{16{load_half[15]}}, load_half};
            LOAD_HU: load_data = {16'b0, load_half};
            LOAD_W:  load_data = mem_rdata;
            default: load_data = ex_q.alu_result;
        endcase
    end

    always_comb begin
        case (ex_q.load_op)
            LOAD_H, LOAD_HU: misaligned = addr_lo[0];
            LOAD_W:          misaligned = (addr_lo != 2'b00);
            default:         misaligned = 1'b0;
        endcase
    end

    // an earlier exception keeps its own code
    assign ale = misaligned && !ex_q.ex_en;

    assign mem_valid = valid_q;

    always_comb begin
        mem_bus.pc         = ex_q.pc;
        mem_bus.rf_we      = ex_q.rf_we && !misaligned;
        mem_bus.rf_waddr   = ex_q.rf_waddr;
        mem_bus.rf_wdata   = load_data;
        mem_bus.csr_re     = ex_q.csr_re;
        mem_bus.csr_we     = ex_q.csr_we;
        mem_bus.csr_num    = ex_q.csr_num;
        mem_bus.csr_wmask  = ex_q.csr_wmask;
        mem_bus.csr_wvalue = ex_q.csr_wvalue;
        mem_bus.ertn       = ex_q.ertn;
        mem_bus.ex_en      = ex_q.ex_en || ale;
        mem_bus.ecode      = ale ? ECODE_ALE : ex_q.ecode;
        mem_bus.esubcode   = ale ? 9'd0 : ex_q.esubcode;
    end

    // the execute stage only hands over defined load kinds
    a_load_op_known: assert property (@(posedge clk) disable iff (!resetn)
        valid_q |-> ex_q.load_op inside {LOAD_NONE, LOAD_B, LOAD_BU, LOAD_H, LOAD_HU, LOAD_W});

endmodule

// File: source/commit_pkg.sv
package commit_pkg;

    // basic data and field widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_B    = 3'd1,
        LOAD_BU   = 3'd2,
        LOAD_H    = 3'd3,
        LOAD_HU   = 3'd4,
        LOAD_W    = 3'd5
    } load_op_e;

    // implemented csr numbers
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;

    localparam ecode_t ECODE_ALE = 6'h9;

    // software writable fields per csr
    localparam word_t CRMD_WMASK   = 32'h0000_01ff;
    localparam word_t PRMD_WMASK   = 32'h0000_0007;
    localparam word_t ESTAT_WMASK  = 32'h0000_0003;
    localparam word_t EENTRY_WMASK = 32'hffff_ffc0;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     alu_result;
        load_op_e  load_op;
        logic      csr_re;
        logic      csr_we;
        csr_num_t  csr_num;
        word_t     csr_wmask;
        word_t     csr_wvalue;
        logic      ertn;
        logic      ex_en;
        ecode_t    ecode;
        esubcode_t esubcode;
    } ex_to_mem_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_wdata;
        logic      csr_re;
        logic      csr_we;
        csr_num_t  csr_num;
        word_t     csr_wmask;
        word_t     csr_wvalue;
        logic      ertn;
        logic      ex_en;
        ecode_t    ecode;
        esubcode_t esubcode;
    } mem_to_wb_t;

    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_wnum;
        word_t     rf_wdata;
    } trace_t;

    typedef struct packed {
        logic     re;
        logic     we;
        csr_num_t num;
        word_t    wmask;
        word_t    wvalue;
    } csr_req_t;

    typedef struct packed {
        logic      ex;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     pc;
        logic      ertn;
    } exc_req_t;

endpackage
